// ==== build.f ====
+incdir+.
ecc_pkg.sv
ecc_66_encode.sv
ecc_66_correct.sv
ecc_word_array.sv
ecc_err_log.sv
ecc_66_mem_top.sv
tb_ecc_66_mem.sv

// ==== tb_ecc_66_mem.sv ====
`timescale 1ns/1ns

`include "ecc_66_consts.svh"

module tb_ecc_66_mem;

    logic             clk;
    logic             rst_n;
    logic             wr_en;
    ecc_pkg::addr_t   wr_addr;
    ecc_pkg::data_t   wr_data;
    ecc_pkg::data_t   wr_flip_data;
    ecc_pkg::parity_t wr_flip_parity;
    logic             rd_en;
    ecc_pkg::addr_t   rd_addr;
    logic             bypass;
    logic             rd_valid;
    ecc_pkg::data_t   rd_data;
    logic             sbit_err;
    logic             dbit_err;
    ecc_pkg::cnt_t    sbit_count;
    ecc_pkg::cnt_t    dbit_count;
    logic             err_seen;
    ecc_pkg::addr_t   err_addr;

    int seed = 2895;
    int errors = 0;

    // Reference model, one entry per address.
    ecc_pkg::data_t   model_data      [`ECC_MEM_DEPTH];
    ecc_pkg::data_t   model_flip_data [`ECC_MEM_DEPTH];
    ecc_pkg::parity_t model_flip_par  [`ECC_MEM_DEPTH];

    ecc_pkg::data_t   exp_data;
    logic             exp_sbit;
    logic             exp_dbit;
    ecc_pkg::cnt_t    exp_scount;
    ecc_pkg::cnt_t    exp_dcount;
    logic             exp_seen;
    ecc_pkg::addr_t   exp_err_addr;

    ecc_66_mem_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_flip_data   (wr_flip_data),
        .wr_flip_parity (wr_flip_parity),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .bypass         (bypass),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .sbit_err       (sbit_err),
        .dbit_err       (dbit_err),
        .sbit_count     (sbit_count),
        .dbit_count     (dbit_count),
        .err_seen       (err_seen),
        .err_addr       (err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_failed(input string msg);
        errors++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error.");
    endtask

    function automatic ecc_pkg::data_t rand_word();
        logic [95:0] raw;
        raw = {$random(seed), $random(seed), $random(seed)};
        return raw[`ECC_DATA_WIDTH-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic write_word(input ecc_pkg::addr_t a, input ecc_pkg::data_t d,
                              input ecc_pkg::data_t fd, input ecc_pkg::parity_t fp);
        @(posedge clk);
        wr_en          <= 1'b1;
        wr_addr        <= a;
        wr_data        <= d;
        wr_flip_data   <= fd;
        wr_flip_parity <= fp;
        model_data[a]      = d;
        model_flip_data[a] = fd;
        model_flip_par[a]  = fp;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic read_word(input ecc_pkg::addr_t a, input logic byp);
        int             flips;
        int             n;
        ecc_pkg::data_t want;
        logic           want_s;
        logic           want_d;
        flips  = $countones(model_flip_data[a]) + $countones(model_flip_par[a]);
        want_s = !byp && (flips == 1);
        want_d = !byp && (flips == 2);
        if (byp || (flips == 2)) begin
            want = model_data[a] ^ model_flip_data[a];  // Nothing is corrected.
        end else begin
            want = model_data[a];
        end
        @(posedge clk);
        rd_en    <= 1'b1;
        rd_addr  <= a;
        bypass   <= byp;
        exp_data <= want;
        exp_sbit <= want_s;
        exp_dbit <= want_d;
        if (want_s) begin
            exp_scount <= exp_scount + 1'b1;
        end
        if (want_d) begin
            exp_dcount <= exp_dcount + 1'b1;
        end
        if ((want_s || want_d) && !exp_seen) begin
            exp_seen     <= 1'b1;
            exp_err_addr <= a;
        end
        @(posedge clk);
        rd_en <= 1'b0;
        n = 0;
        while ((rd_valid !== 1'b1) && (n < 10)) begin
            @(posedge clk);
            n++;
        end
        if (rd_valid !== 1'b1) begin
            check_failed($sformatf("Timeout at %0t ns: rd_valid never rose after a read.",
                                   $time));
        end
        @(posedge clk);  // The error log is checked on this edge.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_rd_data : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> (rd_data == exp_data))
        else check_failed($sformatf("Error at %0t ns: rd_data is %h, expected %h",
                                    $time, $sampled(rd_data), $sampled(exp_data)));

    a_sbit_err : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> (sbit_err == exp_sbit))
        else check_failed($sformatf("Error at %0t ns: sbit_err is %b, expected %b",
                                    $time, $sampled(sbit_err), $sampled(exp_sbit)));

    a_dbit_err : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> (dbit_err == exp_dbit))
        else check_failed($sformatf("Error at %0t ns: dbit_err is %b, expected %b",
                                    $time, $sampled(dbit_err), $sampled(exp_dbit)));

    a_sbit_count : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |=> (sbit_count == exp_scount))
        else check_failed($sformatf("Error at %0t ns: sbit_count is %0d, expected %0d",
                                    $time, $sampled(sbit_count), $sampled(exp_scount)));

    a_dbit_count : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |=> (dbit_count == exp_dcount))
        else check_failed($sformatf("Error at %0t ns: dbit_count is %0d, expected %0d",
                                    $time, $sampled(dbit_count), $sampled(exp_dcount)));

    a_err_seen : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |=> (err_seen == exp_seen))
        else check_failed($sformatf("Error at %0t ns: err_seen is %b, expected %b",
                                    $time, $sampled(err_seen), $sampled(exp_seen)));

    a_err_addr : assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |=> (!exp_seen || (err_addr == exp_err_addr)))
        else check_failed($sformatf("Error at %0t ns: err_addr is %0d, expected %0d",
                                    $time, $sampled(err_addr), $sampled(exp_err_addr)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int b0;
        int b1;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_flip_data = '0;
        wr_flip_parity = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        bypass = 1'b0;
        exp_data = '0;
        exp_sbit = 1'b0;
        exp_dbit = 1'b0;
        exp_scount = '0;
        exp_dcount = '0;
        exp_seen = 1'b0;
        exp_err_addr = '0;
        for (int a = 0; a < `ECC_MEM_DEPTH; a++) begin
            model_data[a] = '0;
            model_flip_data[a] = '0;
            model_flip_par[a] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int a = 0; a < `ECC_MEM_DEPTH; a++) begin  // Clean words.
            write_word(ecc_pkg::addr_t'(a), rand_word(), '0, '0);
        end
        for (int a = 0; a < `ECC_MEM_DEPTH; a++) begin
            read_word(ecc_pkg::addr_t'(a), 1'b0);
        end

        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin  // Every data bit once.
            write_word(ecc_pkg::addr_t'(i % `ECC_MEM_DEPTH), rand_word(),
                       ecc_pkg::data_t'(1) << i, '0);
            read_word(ecc_pkg::addr_t'(i % `ECC_MEM_DEPTH), 1'b0);
        end

        for (int i = 0; i < `ECC_PARITY_WIDTH; i++) begin
            write_word(ecc_pkg::addr_t'(i), rand_word(), '0, ecc_pkg::parity_t'(1) << i);
            read_word(ecc_pkg::addr_t'(i), 1'b0);
        end

        for (int k = 0; k < 12; k++) begin  // Two data bits.
            b0 = {$random(seed)} % `ECC_DATA_WIDTH;
            b1 = (b0 + 1 + ({$random(seed)} % (`ECC_DATA_WIDTH - 1))) % `ECC_DATA_WIDTH;
            write_word(ecc_pkg::addr_t'(k), rand_word(),
                       (ecc_pkg::data_t'(1) << b0) | (ecc_pkg::data_t'(1) << b1), '0);
            read_word(ecc_pkg::addr_t'(k), 1'b0);
        end
        for (int k = 0; k < 4; k++) begin  // One data bit and one check bit.
            b0 = {$random(seed)} % `ECC_DATA_WIDTH;
            write_word(ecc_pkg::addr_t'(k + 3), rand_word(), ecc_pkg::data_t'(1) << b0,
                       ecc_pkg::parity_t'(1) << (k * 2));
            read_word(ecc_pkg::addr_t'(k + 3), 1'b0);
        end
        write_word(ecc_pkg::addr_t'(9), rand_word(), '0, 8'h81);
        read_word(ecc_pkg::addr_t'(9), 1'b0);

        for (int k = 0; k < 8; k++) begin  // Raw words through the bypass.
            b0 = {$random(seed)} % `ECC_DATA_WIDTH;
            write_word(ecc_pkg::addr_t'(k), rand_word(), ecc_pkg::data_t'(1) << b0,
                       ecc_pkg::parity_t'(k));
            read_word(ecc_pkg::addr_t'(k), 1'b1);
        end
        read_word(ecc_pkg::addr_t'(0), 1'b0);

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Checks failed.");
        end
    end

endmodule

// ==== ecc_66_mem_top.sv ====
`timescale 1ns/1ns

module ecc_66_mem_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  ecc_pkg::addr_t   wr_addr,
    input  ecc_pkg::data_t   wr_data,
    input  ecc_pkg::data_t   wr_flip_data,
    input  ecc_pkg::parity_t wr_flip_parity,
    input  logic             rd_en,
    input  ecc_pkg::addr_t   rd_addr,
    input  logic             bypass,
    output logic             rd_valid,
    output ecc_pkg::data_t   rd_data,
    output logic             sbit_err,
    output logic             dbit_err,
    output ecc_pkg::cnt_t    sbit_count,
    output ecc_pkg::cnt_t    dbit_count,
    output logic             err_seen,
    output ecc_pkg::addr_t   err_addr
);

    ecc_pkg::parity_t wr_parity;
    ecc_pkg::data_t   rd_word_data;
    ecc_pkg::parity_t rd_word_parity;
    ecc_pkg::addr_t   rd_addr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ecc_66_encode u_encode (
        .data   (wr_data),
        .parity (wr_parity)
    );

    ecc_word_array #(.word_t(ecc_pkg::data_t)) u_data_array (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_word (wr_data),
        .wr_flip (wr_flip_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word_data)
    );

    ecc_word_array #(.word_t(ecc_pkg::parity_t)) u_parity_array (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_word (wr_parity),
        .wr_flip (wr_flip_parity),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word_parity)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;  // Lines up with the array read registers.
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_addr_q <= rd_addr;  // Address of the word now on rd_data.
        end
    end

    ecc_66_correct u_correct (
        .data_in   (rd_word_data),
        .parity_in (rd_word_parity),
        .bypass    (bypass),
        .data_out  (rd_data),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

    ecc_err_log u_err_log (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_valid),
        .rd_addr_q  (rd_addr_q),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count),
        .err_seen   (err_seen),
        .err_addr   (err_addr)
    );

endmodule

// ==== ecc_err_log.sv ====
`timescale 1ns/1ns

module ecc_err_log (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rd_valid,
    input  ecc_pkg::addr_t rd_addr_q,
    input  logic           sbit_err,
    input  logic           dbit_err,
    output ecc_pkg::cnt_t  sbit_count,
    output ecc_pkg::cnt_t  dbit_count,
    output logic           err_seen,
    output ecc_pkg::addr_t err_addr
);

    logic any_err;
    logic first_err;

    assign any_err   = rd_valid && (sbit_err || dbit_err);
    assign first_err = any_err && !err_seen;  // Only the first flagged read is kept.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Saturating counters and sticky flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
            err_seen   <= 1'b0;
        end else if (rd_valid) begin
            if (sbit_err && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_err && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (first_err) begin
                err_seen <= 1'b1;  // Stays set until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_err) begin
            err_addr <= rd_addr_q;  // Valid only while err_seen is high.
        end
    end

    a_sbit_no_wrap : assert property (
        @(posedge clk) disable iff (!rst_n)
        (sbit_count == '1) |=> (sbit_count == '1)
    ) else $error("Single error counter wrapped.");

    a_dbit_no_wrap : assert property (
        @(posedge clk) disable iff (!rst_n)
        (dbit_count == '1) |=> (dbit_count == '1)
    ) else $error("Double error counter wrapped.");

endmodule

// ==== ecc_word_array.sv ====
`timescale 1ns/1ns

`include "ecc_66_consts.svh"

module ecc_word_array #(
    parameter type word_t = ecc_pkg::data_t
) (
    input  logic           clk,
    input  logic           wr_en,
    input  ecc_pkg::addr_t wr_addr,
    input  word_t          wr_word,
    input  word_t          wr_flip,
    input  logic           rd_en,
    input  ecc_pkg::addr_t rd_addr,
    output word_t          rd_word
);

    word_t mem [`ECC_MEM_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port with error injection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word ^ wr_flip;  // Set flip bits corrupt the stored word.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A read to the address being written sees the old word.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];  // Held until the next read.
        end
    end

    a_wr_addr_known : assert property (
        @(posedge clk) wr_en |-> !$isunknown(wr_addr)
    ) else $error("Write with an unknown address.");

endmodule

// ==== ecc_66_correct.sv ====
`timescale 1ns/1ns

`include "ecc_66_consts.svh"

module ecc_66_correct (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output logic             sbit_err,
    output logic             dbit_err
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Check matrix columns of the data bits, entry 65 first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Every column has odd weight, so two flipped bits never alias one.
    localparam logic [`ECC_DATA_WIDTH-1:0][`ECC_PARITY_WIDTH-1:0] h_col = {
        8'h49, 8'hC8, 8'hC7, 8'h46, 8'h45, 8'hC4, 8'h43, 8'hC2,
        8'hC1, 8'hBF, 8'h3E, 8'h3D, 8'hBC, 8'h3B, 8'hBA, 8'hB9,
        8'h38, 8'h37, 8'hB6, 8'hB5, 8'h34, 8'hB3, 8'h32, 8'h31,
        8'hB0, 8'h2F, 8'hAE, 8'hAD, 8'h2C, 8'hAB, 8'h2A, 8'h29,
        8'hA8, 8'hA7, 8'h26, 8'h25, 8'hA4, 8'h23, 8'hA2, 8'hA1,
        8'h1F, 8'h9E, 8'h9D, 8'h1C, 8'h9B, 8'h1A, 8'h19, 8'h98,
        8'h97, 8'h16, 8'h15, 8'h94, 8'h13, 8'h92, 8'h91, 8'h8F,
        8'h0E, 8'h0D, 8'h8C, 8'h0B, 8'h8A, 8'h89, 8'h07, 8'h86,
        8'h85, 8'h83
    };

    ecc_pkg::parity_t parity_calc;
    ecc_pkg::parity_t syndrome;
    ecc_pkg::data_t   mask;
    logic             syn_zero;
    logic             data_hit;
    logic             parity_hit;

    ecc_66_encode u_encode (
        .data   (data_in),
        .parity (parity_calc)
    );

    assign syndrome = parity_in ^ parity_calc;  // Zero for a clean word.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Syndrome decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        mask = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            mask[i] = (syndrome == h_col[i]);  // Marks the data bit to flip back.
        end
    end

    assign syn_zero   = (syndrome == '0);
    assign data_hit   = |mask;
    // A single set bit points at a flipped check bit; the data is left alone.
    assign parity_hit = !syn_zero && ((syndrome & (syndrome - 1'b1)) == '0);

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && (data_hit || parity_hit);
    assign dbit_err = !bypass && !syn_zero && !data_hit && !parity_hit;

    // The table entries must be distinct for the mask to stay one-hot.
    always_comb begin
        assert final (!(sbit_err && dbit_err))
            else $error("Single and double error flags are both set.");
        assert final ($onehot0(mask))
            else $error("Correction mask has more than one bit set.");
    end

endmodule

// ==== ecc_66_encode.sv ====
`timescale 1ns/1ns

module ecc_66_encode (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Check bit equations, one row of the check matrix each
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign parity[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6] ^ data[8]
        ^ data[10] ^ data[11] ^ data[13] ^ data[15] ^ data[17] ^ data[19] ^ data[21]
        ^ data[23] ^ data[25] ^ data[26] ^ data[28] ^ data[30] ^ data[32] ^ data[34]
        ^ data[36] ^ data[38] ^ data[40] ^ data[42] ^ data[44] ^ data[46] ^ data[48]
        ^ data[50] ^ data[52] ^ data[54] ^ data[56] ^ data[57] ^ data[59] ^ data[61]
        ^ data[63] ^ data[65];

    assign parity[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6] ^ data[9]
        ^ data[10] ^ data[12] ^ data[13] ^ data[16] ^ data[17] ^ data[20] ^ data[21]
        ^ data[24] ^ data[25] ^ data[27] ^ data[28] ^ data[31] ^ data[32] ^ data[35]
        ^ data[36] ^ data[39] ^ data[40] ^ data[43] ^ data[44] ^ data[47] ^ data[48]
        ^ data[51] ^ data[52] ^ data[55] ^ data[56] ^ data[58] ^ data[59] ^ data[62]
        ^ data[63];

    assign parity[2] = data[1] ^ data[2] ^ data[3] ^ data[7] ^ data[8] ^ data[9]
        ^ data[10] ^ data[14] ^ data[15] ^ data[16] ^ data[17] ^ data[22] ^ data[23]
        ^ data[24] ^ data[25] ^ data[29] ^ data[30] ^ data[31] ^ data[32] ^ data[37]
        ^ data[38] ^ data[39] ^ data[40] ^ data[45] ^ data[46] ^ data[47] ^ data[48]
        ^ data[53] ^ data[54] ^ data[55] ^ data[56] ^ data[60] ^ data[61] ^ data[62]
        ^ data[63];

    // Rows 3 to 6 cover contiguous runs of bits.
    assign parity[3] = (^data[10:4]) ^ (^data[25:18]) ^ (^data[40:33])
        ^ (^data[56:49]) ^ (^data[65:64]);
    assign parity[4] = (^data[25:11]) ^ (^data[56:41]);
    assign parity[5] = ^data[56:26];
    assign parity[6] = ^data[65:57];

    assign parity[7] = data[0] ^ data[1] ^ data[2] ^ data[4] ^ data[5] ^ data[7]
        ^ data[10] ^ data[11] ^ data[12] ^ data[14] ^ data[17] ^ data[18] ^ data[21]
        ^ data[23] ^ data[24] ^ data[26] ^ data[27] ^ data[29] ^ data[32] ^ data[33]
        ^ data[36] ^ data[38] ^ data[39] ^ data[41] ^ data[44] ^ data[46] ^ data[47]
        ^ data[50] ^ data[51] ^ data[53] ^ data[56] ^ data[57] ^ data[58] ^ data[60]
        ^ data[63] ^ data[64];

endmodule

// ==== ecc_pkg.sv ====
`include "ecc_66_consts.svh"

package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Payload and control types shared by the ECC memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`ECC_DATA_WIDTH-1:0]   data_t;    // Stored data word.
    typedef logic [`ECC_PARITY_WIDTH-1:0] parity_t;  // Check bits, also the syndrome.
    typedef logic [`ECC_ADDR_WIDTH-1:0]   addr_t;    // Word address.
    typedef logic [`ECC_CNT_WIDTH-1:0]    cnt_t;     // Saturating error count.

endpackage

// ==== ecc_66_consts.svh ====
`ifndef ECC_66_CONSTS_SVH
`define ECC_66_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word geometry of the ECC memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ECC_DATA_WIDTH   66   // One 64b/66b block per word.
`define ECC_PARITY_WIDTH 8    // SEC-DED check bits per word.
`define ECC_MEM_DEPTH    16   // Words in each array.
`define ECC_ADDR_WIDTH   4    // Must cover ECC_MEM_DEPTH.
`define ECC_CNT_WIDTH    8    // Error counters saturate at all ones.

`endif
